// ==== logic/cart_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module cart_core (
  input  wire                       CLK2,
  input  wire                       rst_n,
  // console bus
  input  wire cart_pkg::snes_addr_t snes_addr_in,
  input  wire                       snes_read_in,
  input  wire                       snes_romsel_in,
  input  wire                       snes_cpu_clk_in,
  output cart_pkg::bus_byte_t       snes_data_out,
  output logic                      snes_databus_oe_n,
  // mcu apb
  input  wire                       psel,
  input  wire                       penable,
  input  wire                       pwrite,
  input  wire cart_pkg::snes_addr_t paddr,
  input  wire cart_pkg::bus_byte_t  pwdata,
  output logic                      pready,
  output cart_pkg::bus_byte_t       prdata,
  // rom
  input  wire cart_pkg::rom_word_t  rom_data_in,
  output logic [22:0]               rom_addr,
  output cart_pkg::rom_word_t       rom_data_out,
  output logic                      rom_we,
  output logic                      rom_bhe,
  output logic                      rom_ble
);

  logic                 rom_hit;
  logic                 free_slot;
  logic                 snes_dead;
  cart_pkg::snes_addr_t mapped_addr;

  snes_bus_if bus_if ();
  mcu_rom_if  rom_if ();

  snes_bus_sync u_sync (
    .CLK2(CLK2), .rst_n(rst_n), .snes_addr_in(snes_addr_in), .snes_read_in(snes_read_in),
    .snes_romsel_in(snes_romsel_in), .snes_cpu_clk_in(snes_cpu_clk_in), .bus(bus_if.sampler)
  );

  snes_watchdog u_watchdog (.CLK2(CLK2), .rst_n(rst_n), .bus(bus_if.sink), .snes_dead(snes_dead));

  rom_mapper u_mapper (
    .CLK2(CLK2), .rst_n(rst_n), .bus(bus_if.sink), .rom_hit(rom_hit),
    .mapped_addr(mapped_addr), .free_slot(free_slot)
  );

  mcu_rom_arbiter u_arbiter (
    .CLK2(CLK2), .rst_n(rst_n), .bus(bus_if.sink), .free_slot(free_slot),
    .snes_dead(snes_dead), .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .pready(pready), .prdata(prdata), .rom(rom_if.arbiter)
  );

  rom_port_mux u_port (
    .bus(bus_if.sink), .rom_hit(rom_hit), .mapped_addr(mapped_addr), .rom(rom_if.port),
    .rom_data_in(rom_data_in), .rom_addr(rom_addr), .rom_data_out(rom_data_out),
    .rom_we(rom_we), .rom_bhe(rom_bhe), .rom_ble(rom_ble), .snes_data_out(snes_data_out),
    .snes_databus_oe_n(snes_databus_oe_n)
  );

endmodule

`default_nettype wire

// ==== logic/cart_pkg.sv ====
`default_nettype none

package cart_pkg;

  ////////////////////
  // bus widths
  typedef logic [23:0] snes_addr_t;  // console and mcu byte address
  typedef logic [15:0] rom_word_t;   // rom data bus
  typedef logic [7:0]  bus_byte_t;
  typedef logic [3:0]  rom_delay_t;  // rom cycle down-counter
  typedef logic [17:0] dead_cnt_t;   // console watchdog

  // mcu rom access scheduler
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RD_ADDR,
    ST_RD_END,
    ST_WR_ADDR,
    ST_WR_END
  } arb_state_e;

  ////////////////////
  // timing
  localparam int         SYNC_TAPS     = 8;
  localparam rom_delay_t ROM_CYCLE_LEN = 4'd8;
  localparam dead_cnt_t  DEAD_TIMEOUT  = 18'd96000;  // about 1 ms of low console clock
  localparam snes_addr_t ROM_MASK      = 24'h3f_ffff; // 4 MiB rom

endpackage

`default_nettype wire

// ==== logic/mcu_rom_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module mcu_rom_arbiter (
  input  wire                       CLK2,
  input  wire                       rst_n,
  snes_bus_if.sink                  bus,
  input  wire                       free_slot,
  input  wire                       snes_dead,
  input  wire                       psel,
  input  wire                       penable,
  input  wire                       pwrite,
  input  wire cart_pkg::snes_addr_t paddr,
  input  wire cart_pkg::bus_byte_t  pwdata,
  output logic                      pready,
  output cart_pkg::bus_byte_t       prdata,
  mcu_rom_if.arbiter                rom
);

  cart_pkg::arb_state_e state;
  cart_pkg::rom_delay_t delay;
  cart_pkg::snes_addr_t req_addr;
  cart_pkg::bus_byte_t  req_wdata;
  logic                 rd_pend;
  logic                 wr_pend;
  logic                 accept;
  logic                 restart;

  ////////////////////
  // apb side
  assign accept = psel & penable & ~rd_pend & ~wr_pend & ~pready;

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      pready  <= 1'b0;
    end else begin
      pready <= 1'b0;  // single-cycle ready
      if (accept) begin
        rd_pend <= ~pwrite;
        wr_pend <= pwrite;
      end else if (state == cart_pkg::ST_RD_END || state == cart_pkg::ST_WR_END) begin
        rd_pend <= 1'b0;
        wr_pend <= 1'b0;
        pready  <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK2) begin
    if (accept) begin
      req_addr  <= paddr;
      req_wdata <= pwdata;
    end
    if (state == cart_pkg::ST_RD_ADDR) prdata <= rom.rom_byte;  // last sample wins
  end

  ////////////////////
  // rom scheduler
  // raw clock high while the filtered one is still low means the console just woke up
  assign restart = snes_dead & bus.cpu_clk_raw & ~bus.cpu_clk;

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      state <= cart_pkg::ST_IDLE;
      delay <= '0;
    end else if (restart) begin
      state <= cart_pkg::ST_IDLE;  // pending flags stay set, access is retried
    end else begin
      case (state)
        cart_pkg::ST_IDLE: begin
          if (free_slot | snes_dead) begin
            delay <= cart_pkg::ROM_CYCLE_LEN;
            if (rd_pend) state <= cart_pkg::ST_RD_ADDR;
            else if (wr_pend) state <= cart_pkg::ST_WR_ADDR;
          end
        end
        cart_pkg::ST_RD_ADDR: begin
          delay <= delay - 1'b1;
          if (delay == '0) state <= cart_pkg::ST_RD_END;
        end
        cart_pkg::ST_WR_ADDR: begin
          delay <= delay - 1'b1;
          if (delay == '0) state <= cart_pkg::ST_WR_END;
        end
        default: state <= cart_pkg::ST_IDLE;  // both end states
      endcase
    end
  end

  assign rom.busy     = (state != cart_pkg::ST_IDLE);
  assign rom.we_phase = (state == cart_pkg::ST_WR_ADDR);
  assign rom.addr     = req_addr;
  assign rom.wdata    = req_wdata;

endmodule

`default_nettype wire

// ==== logic/mcu_rom_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// arbiter request towards the rom port, read byte coming back
interface mcu_rom_if;
  logic                 busy;      // mcu owns the rom
  logic                 we_phase;  // write strobe window
  cart_pkg::snes_addr_t addr;
  cart_pkg::bus_byte_t  wdata;
  cart_pkg::bus_byte_t  rom_byte;  // lane picked by addr bit 0

  modport arbiter (output busy, we_phase, addr, wdata, input rom_byte);

  modport port (input busy, we_phase, addr, wdata, output rom_byte);

endinterface

`default_nettype wire

// ==== logic/rom_mapper.sv ====
`timescale 1ns/10ps
`default_nettype none

module rom_mapper (
  input  wire                  CLK2,
  input  wire                  rst_n,
  snes_bus_if.sink             bus,
  output logic                 rom_hit,
  output cart_pkg::snes_addr_t mapped_addr,
  output logic                 free_slot
);

  logic free_strobe;  // console cycle that leaves the rom alone

  // fixed rom-only map
  assign rom_hit     = ~bus.romsel;
  assign mapped_addr = bus.addr & cart_pkg::ROM_MASK;  // larger addresses wrap

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= bus.cycle_start & ~rom_hit;
    end
  end

  // rom is free after each console cycle and during non-rom cycles
  assign free_slot = bus.cycle_end | free_strobe;

endmodule

`default_nettype wire

// ==== logic/rom_port_mux.sv ====
`timescale 1ns/10ps
`default_nettype none

module rom_port_mux (
  snes_bus_if.sink                  bus,
  input  wire                       rom_hit,
  input  wire cart_pkg::snes_addr_t mapped_addr,
  mcu_rom_if.port                   rom,
  input  wire cart_pkg::rom_word_t  rom_data_in,
  output logic [22:0]               rom_addr,
  output cart_pkg::rom_word_t       rom_data_out,
  output logic                      rom_we,
  output logic                      rom_bhe,
  output logic                      rom_ble,
  output cart_pkg::bus_byte_t       snes_data_out,
  output logic                      snes_databus_oe_n
);

  cart_pkg::snes_addr_t sel_addr;
  cart_pkg::bus_byte_t  rd_byte;
  logic                 addr0;

  // mcu takes the rom only inside its own access window
  assign sel_addr = rom.busy ? rom.addr : mapped_addr;
  assign rom_addr = sel_addr[23:1];  // word address
  assign addr0    = sel_addr[0];

  ////////////////////
  // byte lanes, odd address uses the low byte
  assign rd_byte      = addr0 ? rom_data_in[7:0] : rom_data_in[15:8];
  assign rom.rom_byte = rd_byte;
  assign rom_data_out = addr0 ? {8'h00, rom.wdata} : {rom.wdata, 8'h00};
  assign rom_bhe      = addr0;
  assign rom_ble      = ~addr0;
  assign rom_we       = ~rom.we_phase;  // active low

  // console read path
  assign snes_data_out     = rd_byte;
  assign snes_databus_oe_n = ~(~bus.read & rom_hit);

endmodule

`default_nettype wire

// ==== logic/snes_bus_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// filtered console bus, one driver and many readers
interface snes_bus_if;
  cart_pkg::snes_addr_t addr;
  logic                 romsel;       // active low
  logic                 read;         // active low
  logic                 cpu_clk;
  logic                 cpu_clk_raw;  // unfiltered first sample
  logic                 cycle_start;  // one-cycle pulse on clock rise
  logic                 cycle_end;    // one-cycle pulse on clock fall

  modport sampler (output addr, romsel, read, cpu_clk, cpu_clk_raw, cycle_start, cycle_end);
  modport sink    (input  addr, romsel, read, cpu_clk, cpu_clk_raw, cycle_start, cycle_end);

endinterface

`default_nettype wire

// ==== logic/snes_bus_sync.sv ====
`timescale 1ns/10ps
`default_nettype none

module snes_bus_sync (
  input  wire                       CLK2,
  input  wire                       rst_n,
  input  wire cart_pkg::snes_addr_t snes_addr_in,
  input  wire                       snes_read_in,
  input  wire                       snes_romsel_in,
  input  wire                       snes_cpu_clk_in,
  snes_bus_if.sampler               bus
);

  logic [cart_pkg::SYNC_TAPS-1:0] read_r;
  logic [cart_pkg::SYNC_TAPS-1:0] romsel_r;
  logic [cart_pkg::SYNC_TAPS-1:0] clk_r;
  cart_pkg::snes_addr_t           addr_r [7];

  ////////////////////
  // sampling shift registers, tap 0 is the newest sample
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      read_r   <= '1;  // strobes idle high
      romsel_r <= '1;
      clk_r    <= '0;
    end else begin
      read_r   <= {read_r[cart_pkg::SYNC_TAPS-2:0], snes_read_in};
      romsel_r <= {romsel_r[cart_pkg::SYNC_TAPS-2:0], snes_romsel_in};
      clk_r    <= {clk_r[cart_pkg::SYNC_TAPS-2:0], snes_cpu_clk_in};
    end
  end

  always_ff @(posedge CLK2) begin
    addr_r[0] <= snes_addr_in;
    for (int i = 1; i < 7; i++) begin
      addr_r[i] <= addr_r[i-1];
    end
  end

  // two-tap filter, a bit must be seen twice to count as high
  assign bus.addr        = addr_r[5] & addr_r[4];  // address settles late
  assign bus.read        = read_r[2] & read_r[1];
  assign bus.romsel      = romsel_r[2] & romsel_r[1];
  assign bus.cpu_clk     = clk_r[2] & clk_r[1];
  assign bus.cpu_clk_raw = clk_r[0];

  // edge needs five stable samples before it
  assign bus.cycle_start = (clk_r[6:1] == 6'b000001);
  assign bus.cycle_end   = (clk_r[6:1] == 6'b111110);

endmodule

`default_nettype wire

// ==== logic/snes_watchdog.sv ====
`timescale 1ns/10ps
`default_nettype none

module snes_watchdog (
  input  wire      CLK2,
  input  wire      rst_n,
  snes_bus_if.sink bus,
  output logic     snes_dead
);

  cart_pkg::dead_cnt_t dead_cnt;  // cycles with console clock low

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      dead_cnt  <= '0;
      snes_dead <= 1'b0;
    end else if (bus.cpu_clk_raw) begin
      dead_cnt  <= '0;  // console clock is back
      snes_dead <= 1'b0;
    end else begin
      if (dead_cnt != '1) dead_cnt <= dead_cnt + 1'b1;  // saturate
      if (dead_cnt > cart_pkg::DEAD_TIMEOUT) snes_dead <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the cart_core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_cart_core \
  -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Result: PASSED" sim.log; then
  exit 0
fi
exit 1

// ==== src.f ====
logic/cart_pkg.sv
logic/snes_bus_if.sv
logic/mcu_rom_if.sv
logic/snes_bus_sync.sv
logic/snes_watchdog.sv
logic/rom_mapper.sv
logic/mcu_rom_arbiter.sv
logic/rom_port_mux.sv
logic/cart_core.sv
test/cart_assertions.sv
test/cart_checker.sv
test/tb_cart_core.sv

// ==== test/cart_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module cart_assertions (
  input wire CLK2,
  input wire rst_n,
  input wire rom_bhe,
  input wire rom_ble,
  input wire pready,
  input wire psel,
  input wire penable,
  input wire rom_we,
  input wire busy
);

  // exactly one byte lane enabled at any time
  a_one_lane: assert property (@(posedge CLK2) disable iff (!rst_n) rom_bhe != rom_ble)
    else $error("both rom byte enables at the same level");

  a_ready_in_access: assert property (@(posedge CLK2) disable iff (!rst_n)
    pready |-> (psel && penable))
    else $error("pready raised outside an apb access phase");

  a_we_when_busy: assert property (@(posedge CLK2) disable iff (!rst_n) !rom_we |-> busy)
    else $error("rom write enable low while the arbiter is idle");

endmodule

`default_nettype wire

// ==== test/cart_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module cart_checker (
  input  wire                       CLK2,
  input  wire                       rst_n,
  input  int                        test_id,
  input  wire cart_pkg::snes_addr_t snes_addr_in,
  input  wire cart_pkg::bus_byte_t  snes_data_out,
  input  wire                       snes_databus_oe_n,
  input  wire                       psel,
  input  wire                       pwrite,
  input  wire cart_pkg::snes_addr_t paddr,
  input  wire cart_pkg::bus_byte_t  pwdata,
  input  wire                       pready,
  input  wire cart_pkg::bus_byte_t  prdata,
  input  wire [22:0]                rom_addr,
  input  wire cart_pkg::rom_word_t  rom_data_out,
  input  wire                       rom_we,
  input  wire                       rom_bhe,
  input  wire                       rom_ble,
  output int                        checks,
  output int                        errors
);

  cart_pkg::bus_byte_t shadow [cart_pkg::snes_addr_t];  // bytes written over apb
  int                  last_id;
  int                  t_checks;
  int                  t_errors;
  logic                pready_q;

  initial begin
    checks   = 0;
    errors   = 0;
    last_id  = 0;
    pready_q = 1'b0;
  end

  // contents of an untouched rom byte
  function automatic cart_pkg::bus_byte_t fill_byte(input cart_pkg::snes_addr_t a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'ha5;
  endfunction

  function automatic cart_pkg::bus_byte_t expect_byte(input cart_pkg::snes_addr_t a);
    return shadow.exists(a) ? shadow[a] : fill_byte(a);
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1:       return "reset state";
      2:       return "apb write/read with console running";
      3:       return "console rom reads";
      4:       return "dead console";
      default: return "byte lanes";
    endcase
  endfunction

  task automatic check(input logic ok, input string msg);
    checks++;
    t_checks++;
    if (!ok) begin
      errors++;
      t_errors++;
      $display("FAIL %0t ns: test %0d %s", $time, test_id, msg);
    end
  endtask

  ////////////////////
  // compare on the falling edge, away from stimulus
  always @(negedge CLK2) begin
    if (test_id != last_id) begin
      if (last_id > 0)
        $display("test %0d %s: %0d checks, %0d errors", last_id, test_name(last_id),
                 t_checks, t_errors);
      t_checks = 0;
      t_errors = 0;
      last_id  = test_id;
    end
    if (rst_n) begin
      if (test_id == 1) check(!pready && rom_we && snes_databus_oe_n, "outputs not idle");
      if (pready) begin
        check(!pready_q, "pready high for more than one cycle");
        if (pwrite) shadow[paddr] = pwdata;  // write takes effect at end of transfer
        else check(prdata == expect_byte(paddr),
                   $sformatf("apb read %h got %h expected %h", paddr, prdata,
                             expect_byte(paddr)));
      end
      if (!rom_we) begin
        check(rom_bhe == paddr[0] && rom_ble == !paddr[0] && rom_addr == paddr[23:1],
              $sformatf("write to %h with rom_addr %h bhe %b ble %b", paddr, rom_addr,
                        rom_bhe, rom_ble));
        check((paddr[0] ? rom_data_out[7:0] : rom_data_out[15:8]) == pwdata,
              $sformatf("write byte %h missing on lane, data %h", pwdata, rom_data_out));
      end
      // console only owns the rom when no apb access is in flight
      if (!snes_databus_oe_n && !psel)
        check(snes_data_out == expect_byte(snes_addr_in & cart_pkg::ROM_MASK),
              $sformatf("console read %h got %h expected %h", snes_addr_in, snes_data_out,
                        expect_byte(snes_addr_in & cart_pkg::ROM_MASK)));
    end
    pready_q = pready;
  end

endmodule

`default_nettype wire

// ==== test/tb_cart_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_cart_core;

  localparam int CON_PERIOD = 24;  // console clock period in CLK2 cycles
  localparam int N_ACC      = 88;  // apb accesses over all tests
  localparam int LIMIT      = cart_pkg::DEAD_TIMEOUT + 64 * N_ACC * CON_PERIOD;
  localparam cart_pkg::snes_addr_t WIN = 24'h01_2340;  // apb test window

  logic                 CLK2 = 1'b0;
  logic                 rst_n;
  cart_pkg::snes_addr_t snes_addr_in;
  logic                 snes_read_in;
  logic                 snes_romsel_in;
  logic                 snes_cpu_clk_in;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  cart_pkg::snes_addr_t paddr;
  cart_pkg::bus_byte_t  pwdata;
  cart_pkg::rom_word_t  rom_data_in;
  logic                 pready;
  cart_pkg::bus_byte_t  prdata;
  logic [22:0]          rom_addr;
  cart_pkg::rom_word_t  rom_data_out;
  logic                 rom_we;
  logic                 rom_bhe;
  logic                 rom_ble;
  cart_pkg::bus_byte_t  snes_data_out;
  logic                 snes_databus_oe_n;
  logic                 console_on;
  int                   con_cnt;
  int                   test_id;
  int                   cycles;
  int                   checks;
  int                   errors;
  cart_pkg::snes_addr_t addrs [24];
  logic [15:0]          rom_mem [0:2**21-1];  // 4 MiB rom model

  cart_core u_cart_core (.*);

  cart_checker u_checker (.*);

  bind cart_core cart_assertions u_assertions (
    .CLK2(CLK2), .rst_n(rst_n), .rom_bhe(rom_bhe), .rom_ble(rom_ble), .pready(pready),
    .psel(psel), .penable(penable), .rom_we(rom_we), .busy(rom_if.busy)
  );

  always #50 CLK2 = ~CLK2;

  function automatic cart_pkg::bus_byte_t pattern_byte(input cart_pkg::snes_addr_t a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'ha5;
  endfunction

  // window address, upper bits random so they wrap under the rom mask
  function automatic cart_pkg::snes_addr_t console_addr();
    return (WIN + ($urandom % 64)) | (24'($urandom % 4) << 22);
  endfunction

  ////////////////////
  // rom model
  assign rom_data_in = rom_mem[rom_addr[20:0]];

  always @(posedge CLK2) begin
    if (!rom_we) begin
      if (!rom_ble) rom_mem[rom_addr[20:0]][7:0] <= rom_data_out[7:0];
      if (!rom_bhe) rom_mem[rom_addr[20:0]][15:8] <= rom_data_out[15:8];
    end
  end

  // console bus, address settles well before read goes low
  always @(posedge CLK2) begin
    if (!console_on) begin
      con_cnt         <= 0;
      snes_cpu_clk_in <= 1'b0;
      snes_read_in    <= 1'b1;
      snes_romsel_in  <= 1'b1;
    end else begin
      con_cnt <= (con_cnt == CON_PERIOD - 1) ? 0 : con_cnt + 1;
      case (con_cnt)
        0: begin
          snes_cpu_clk_in <= 1'b1;
          snes_read_in    <= 1'($urandom % 2);
          snes_romsel_in  <= ($urandom % 4) == 0;  // rom hit most of the time
        end
        10: begin
          snes_read_in   <= 1'b1;
          snes_romsel_in <= 1'b1;
        end
        12: snes_cpu_clk_in <= 1'b0;
        16: snes_addr_in <= console_addr();
        default: ;
      endcase
    end
  end

  always @(posedge CLK2) begin
    cycles <= cycles + 1;
    if (cycles > LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("Result: FAILED");
      $finish;
    end
  end

  task automatic apb_xfer(input logic wr, input cart_pkg::snes_addr_t a,
                          input cart_pkg::bus_byte_t d);
    @(posedge CLK2);
    psel    <= 1'b1;
    pwrite  <= wr;
    paddr   <= a;
    pwdata  <= d;
    @(posedge CLK2);
    penable <= 1'b1;
    do @(posedge CLK2); while (!pready);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic write_read_block(input int n, input logic seq);
    for (int i = 0; i < n; i++) begin
      addrs[i] = seq ? WIN + 128 + i : WIN + ($urandom % 64);
      apb_xfer(1'b1, addrs[i], 8'($urandom));
    end
    for (int i = 0; i < n; i++) apb_xfer(1'b0, addrs[i], 8'h00);
  endtask

  initial begin
    void'($urandom(80135));
    for (int i = 0; i < 2**21; i++)
      rom_mem[i] = {pattern_byte(24'(i * 2)), pattern_byte(24'(i * 2 + 1))};
    rst_n = 1'b0;
    snes_addr_in = '0;
    snes_read_in = 1'b1;
    snes_romsel_in = 1'b1;
    snes_cpu_clk_in = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    console_on = 1'b0;
    test_id = 0;
    cycles = 0;
    repeat (5) @(posedge CLK2);
    rst_n   <= 1'b1;
    test_id <= 1;
    repeat (10) @(posedge CLK2);
    test_id    <= 2;
    console_on <= 1'b1;
    write_read_block(24, 1'b0);
    test_id <= 3;
    repeat (40 * CON_PERIOD) @(posedge CLK2);
    test_id    <= 4;
    console_on <= 1'b0;
    repeat (cart_pkg::DEAD_TIMEOUT + 100) @(posedge CLK2);
    write_read_block(8, 1'b0);
    console_on <= 1'b1;  // clock restarts
    write_read_block(4, 1'b0);
    test_id <= 5;
    write_read_block(8, 1'b1);
    test_id <= 6;
    repeat (2) @(posedge CLK2);
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) $display("Result: PASSED");
    else $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire
